/* alu_pkg.sv */
package alu_pkg;

	// Operand and result widths
	localparam int data_w = 32;
	localparam int result_w = 2 * data_w;

	// Iteration cycles of the multiply/divide unit
	localparam int muldiv_cycles = 32;

	typedef logic [4:0] op_t;

	// Memory access and immediate forms
	localparam op_t op_load = 5'b00000;
	localparam op_t op_loadi = 5'b00001;
	localparam op_t op_store = 5'b00010;

	// Register arithmetic
	localparam op_t op_add = 5'b00011;
	localparam op_t op_sub = 5'b00100;
	localparam op_t op_shr = 5'b00101;
	localparam op_t op_shl = 5'b00110;
	localparam op_t op_ror = 5'b00111;
	localparam op_t op_rol = 5'b01000;
	localparam op_t op_and = 5'b01001;
	localparam op_t op_or = 5'b01010;

	localparam op_t op_addi = 5'b01011;
	localparam op_t op_andi = 5'b01100;
	localparam op_t op_ori = 5'b01101;

	localparam op_t op_mul = 5'b01110;
	localparam op_t op_div = 5'b01111;

	// Unary forms work on operand b
	localparam op_t op_neg = 5'b10000;
	localparam op_t op_not = 5'b10001;

	localparam op_t op_branch = 5'b10010;

	localparam op_t op_mfhi = 5'b10111;
	localparam op_t op_mflo = 5'b11000;

	localparam op_t op_nop = 5'b11001;
	localparam op_t op_halt = 5'b11010;

	// Kind of result handed from the simple unit to the merge
	localparam logic [1:0] kind_normal = 2'd0;
	localparam logic [1:0] kind_mfhi = 2'd1;
	localparam logic [1:0] kind_mflo = 2'd2;
	localparam logic [1:0] kind_none = 2'd3;

endpackage

/* alu_simple_unit.sv */
module alu_simple_unit
	import alu_pkg::*;
#(
	parameter int width = data_w
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             simple_valid,
	input  op_t              opcode,
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             branch_flag,
	output logic             simple_done,
	output logic [width-1:0] simple_result,
	output logic [1:0]       simple_kind
);

	localparam int sh_w = $clog2(width);

	logic [sh_w-1:0]    amt;
	logic [width-1:0]   sum;
	logic [width-1:0]   diff;
	logic [2*width-1:0] ror_ext;
	logic [2*width-1:0] rol_ext;
	logic [width-1:0]   res_d;
	logic [1:0]         kind_d;

	// Shift and rotate amounts wrap at the word size
	assign amt = b[sh_w-1:0];

	assign sum = a + b;
	assign diff = a - b;

	// Rotates come out of a doubled copy of the operand
	assign ror_ext = {a, a} >> amt;
	assign rol_ext = {a, a} << amt;

	always_comb begin
		res_d = '0;
		kind_d = kind_normal;
		case (opcode)
			op_add: begin
				res_d = sum;
			end
			op_sub: begin
				res_d = diff;
			end
			op_shr: begin
				res_d = a >> amt;
			end
			op_shl: begin
				res_d = a << amt;
			end
			op_ror: begin
				res_d = ror_ext[width-1:0];
			end
			op_rol: begin
				res_d = rol_ext[2*width-1:width];
			end
			op_and, op_andi: begin
				res_d = a & b;
			end
			op_or, op_ori: begin
				res_d = a | b;
			end
			op_neg: begin
				res_d = -b;
			end
			op_not: begin
				res_d = ~b;
			end
			// Effective address add
			op_load, op_loadi, op_store, op_addi: begin
				res_d = sum;
			end
			op_branch: begin
				if (branch_flag) begin
					res_d = sum;
				end else begin
					res_d = a;
				end
			end
			op_mfhi: begin
				kind_d = kind_mfhi;
			end
			op_mflo: begin
				kind_d = kind_mflo;
			end
			op_nop, op_halt: begin
				kind_d = kind_none;
			end
			default: begin
				res_d = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			simple_done <= 1'b0;
		end else begin
			simple_done <= simple_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (simple_valid) begin
			simple_result <= res_d;
			simple_kind <= kind_d;
		end
	end

	// Multiply and divide belong to the multi-cycle unit
	a_no_muldiv_op: assert property (
		@(posedge clk) disable iff (!rst_n)
		simple_valid |-> (opcode != op_mul) && (opcode != op_div)
	);

endmodule

/* alu_muldiv_unit.sv */
module alu_muldiv_unit
	import alu_pkg::*;
#(
	parameter int width = data_w
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  logic             is_div,
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic             md_done,
	output logic [width-1:0] md_hi,
	output logic [width-1:0] md_lo,
	output logic             running
);

	localparam int cnt_w = $clog2(muldiv_cycles + 1);

	logic [cnt_w-1:0]   cnt;
	logic               fix_q;
	logic               step_en;

	logic [width-1:0]   ua;
	logic [width-1:0]   ub;

	// acc is the upper product half or the partial remainder
	logic [width-1:0]   acc;
	logic [width-1:0]   lo_r;
	logic [width-1:0]   m;
	logic [width-1:0]   dvd;
	logic               div_q;
	logic               neg_res;
	logic               neg_rem;
	logic               div_zero;

	logic [width:0]     add_sum;
	logic [width:0]     shifted;
	logic [width:0]     trial;
	logic [2*width-1:0] prod;
	logic [2*width-1:0] prod_fix;

	assign ua = a[width-1] ? -a : a;
	assign ub = b[width-1] ? -b : b;

	// Narrow operands finish early and idle until the fixed latency ends
	assign step_en = int'(cnt) < width;

	assign add_sum = {1'b0, acc} + {1'b0, m};
	assign shifted = {acc, lo_r[width-1]};
	assign trial = shifted - {1'b0, m};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			fix_q <= 1'b0;
			cnt <= '0;
		end else if (start && !running) begin
			running <= 1'b1;
			fix_q <= 1'b0;
			cnt <= '0;
		end else if (running) begin
			if (fix_q) begin
				running <= 1'b0;
				fix_q <= 1'b0;
			end else begin
				cnt <= cnt + 1'b1;
				if (cnt == cnt_w'(muldiv_cycles - 1)) begin
					fix_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !running) begin
			acc <= '0;
			lo_r <= ua;
			m <= ub;
			dvd <= a;
			div_q <= is_div;
			neg_res <= a[width-1] ^ b[width-1];
			neg_rem <= a[width-1];
			div_zero <= (b == '0);
		end else if (running && !fix_q && step_en) begin
			if (div_q) begin
				// Restoring step, keep the shifted remainder on a borrow
				if (!trial[width]) begin
					acc <= trial[width-1:0];
					lo_r <= {lo_r[width-2:0], 1'b1};
				end else begin
					acc <= shifted[width-1:0];
					lo_r <= {lo_r[width-2:0], 1'b0};
				end
			end else if (lo_r[0]) begin
				{acc, lo_r} <= {add_sum, lo_r[width-1:1]};
			end else begin
				{acc, lo_r} <= {1'b0, acc, lo_r[width-1:1]};
			end
		end
	end

	assign prod = {acc, lo_r};
	assign prod_fix = neg_res ? -prod : prod;

	// Sign fix happens in the last cycle of the operation
	always_comb begin
		if (div_q) begin
			if (div_zero) begin
				md_lo = '1;
				md_hi = dvd;
			end else begin
				md_lo = neg_res ? -lo_r : lo_r;
				md_hi = neg_rem ? -acc : acc;
			end
		end else begin
			{md_hi, md_lo} = prod_fix;
		end
	end

	assign md_done = fix_q;

	a_no_start_while_running: assert property (
		@(posedge clk) disable iff (!rst_n)
		running |-> !start
	);

	// Remainder magnitude stays below the divisor magnitude
	a_rem_below_divisor: assert property (
		@(posedge clk) disable iff (!rst_n)
		(md_done && div_q && !div_zero) |-> (acc < m)
	);

endmodule

/* alu_result_merge.sv */
module alu_result_merge
	import alu_pkg::*;
#(
	parameter int width = data_w
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                simple_done,
	input  logic [width-1:0]    simple_result,
	input  logic [1:0]          simple_kind,
	input  logic                md_done,
	input  logic [width-1:0]    md_hi,
	input  logic [width-1:0]    md_lo,
	input  logic                running,
	output logic                result_valid,
	output logic [result_w-1:0] result,
	output logic                busy,
	output logic                pending
);

	logic [width-1:0] hi_q;
	logic [width-1:0] lo_q;
	logic             md_valid_q;
	logic             simple_out;

	// halt and nop produce no result
	assign simple_out = simple_done && (simple_kind != kind_none);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			md_valid_q <= 1'b0;
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			result_valid <= md_done | simple_out;
			md_valid_q <= md_done;
			if (md_done) begin
				hi_q <= md_hi;
				lo_q <= md_lo;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (md_done) begin
			result <= result_w'({md_hi, md_lo});
		end else if (simple_done) begin
			case (simple_kind)
				kind_mfhi: result <= result_w'(hi_q);
				kind_mflo: result <= result_w'(lo_q);
				default:   result <= result_w'(simple_result);
			endcase
		end
	end

	// Busy stretches over the cycle that carries the multiply/divide result
	assign busy = running | md_valid_q;

	// A single-cycle result sits in the merge stage
	assign pending = simple_done;

	a_no_result_collision: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(simple_done && md_done)
	);

endmodule

/* alu_core.sv */
module alu_core
	import alu_pkg::*;
#(
	parameter int width = data_w
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                op_valid,
	input  op_t                 opcode,
	input  logic [width-1:0]    a,
	input  logic [width-1:0]    b,
	input  logic                branch_flag,
	output logic                result_valid,
	output logic [result_w-1:0] result,
	output logic                busy
);

	logic             accept;
	logic             is_md;
	logic             md_start;
	logic             simple_valid;
	logic             pending;
	logic             simple_done;
	logic [width-1:0] simple_result;
	logic [1:0]       simple_kind;
	logic             md_done;
	logic [width-1:0] md_hi;
	logic [width-1:0] md_lo;
	logic             muldiv_running;

	assign accept = op_valid & ~busy;
	assign is_md = (opcode == op_mul) || (opcode == op_div);

	// Multiply/divide waits until no single-cycle op is left in flight
	assign md_start = accept & is_md & ~pending;
	assign simple_valid = accept & ~is_md;

	alu_simple_unit #(
		.width (width)
	) u_simple (
		.clk           (clk),
		.rst_n         (rst_n),
		.simple_valid  (simple_valid),
		.opcode        (opcode),
		.a             (a),
		.b             (b),
		.branch_flag   (branch_flag),
		.simple_done   (simple_done),
		.simple_result (simple_result),
		.simple_kind   (simple_kind)
	);

	alu_muldiv_unit #(
		.width (width)
	) u_muldiv (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (md_start),
		.is_div  (opcode == op_div),
		.a       (a),
		.b       (b),
		.md_done (md_done),
		.md_hi   (md_hi),
		.md_lo   (md_lo),
		.running (muldiv_running)
	);

	alu_result_merge #(
		.width (width)
	) u_merge (
		.clk           (clk),
		.rst_n         (rst_n),
		.simple_done   (simple_done),
		.simple_result (simple_result),
		.simple_kind   (simple_kind),
		.md_done       (md_done),
		.md_hi         (md_hi),
		.md_lo         (md_lo),
		.running       (muldiv_running),
		.result_valid  (result_valid),
		.result        (result),
		.busy          (busy),
		.pending       (pending)
	);

endmodule

/* tb_alu_core.sv */
module tb_alu_core
	import alu_pkg::*;
();

	timeunit 1ns;
	timeprecision 10ps;

	localparam int n_simple_ops = 17;
	localparam int n_reps = 200;
	localparam int n_md_rand = 20;
	// Random streams plus the directed operations
	localparam int n_ops = n_simple_ops * n_reps + 4 * n_md_rand + 200;

	logic                clk;
	logic                rst_n;
	logic                op_valid;
	op_t                 opcode;
	logic [data_w-1:0]   a;
	logic [data_w-1:0]   b;
	logic                branch_flag;
	logic                result_valid;
	logic [result_w-1:0] result;
	logic                busy;

	logic [result_w-1:0] exp_q[$];
	int                  due_q[$];
	string               name_q[$];
	int                  cyc;
	int                  pass_cnt;
	int                  fail_cnt;
	int                  test_base;
	logic [data_w-1:0]   hi_m;
	logic [data_w-1:0]   lo_m;

	alu_core #(
		.width (data_w)
	) u_alu_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_valid     (op_valid),
		.opcode       (opcode),
		.a            (a),
		.b            (b),
		.branch_flag  (branch_flag),
		.result_valid (result_valid),
		.result       (result),
		.busy         (busy)
	);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

	initial begin
		cyc = 0;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic op_t simple_op(input int i);
		op_t o;
		case (i)
			0: o = op_add;
			1: o = op_sub;
			2: o = op_shr;
			3: o = op_shl;
			4: o = op_ror;
			5: o = op_rol;
			6: o = op_and;
			7: o = op_or;
			8: o = op_neg;
			9: o = op_not;
			10: o = op_addi;
			11: o = op_andi;
			12: o = op_ori;
			13: o = op_branch;
			14: o = op_load;
			15: o = op_loadi;
			default: o = op_store;
		endcase
		return o;
	endfunction

	function automatic logic [result_w-1:0] expected_result(
		input op_t               op,
		input logic [data_w-1:0] x,
		input logic [data_w-1:0] y,
		input logic              flag,
		input logic [data_w-1:0] hi,
		input logic [data_w-1:0] lo
	);
		int                  n;
		longint              sx;
		longint              sy;
		logic [data_w-1:0]   r;
		logic [result_w-1:0] res;
		n = y % data_w;
		sx = $signed(x);
		sy = $signed(y);
		r = '0;
		res = '0;
		case (op)
			op_add, op_addi, op_load, op_loadi, op_store: r = x + y;
			op_sub: r = x - y;
			op_shr: r = x >> n;
			op_shl: r = x << n;
			op_ror: r = (x >> n) | (x << (data_w - n));
			op_rol: r = (x << n) | (x >> (data_w - n));
			op_and, op_andi: r = x & y;
			op_or, op_ori: r = x | y;
			op_neg: r = -y;
			op_not: r = ~y;
			op_branch: r = flag ? x + y : x;
			op_mfhi: r = hi;
			op_mflo: r = lo;
			default: r = '0;
		endcase
		res = {{data_w{1'b0}}, r};
		if (op == op_mul) begin
			res = sx * sy;
		end else if (op == op_div) begin
			// Divide by zero keeps the dividend in HI
			if (y == '0) begin
				res = {x, {data_w{1'b1}}};
			end else begin
				res = {data_w'(sx % sy), data_w'(sx / sy)};
			end
		end
		return res;
	endfunction

	task automatic check(
		input string               name,
		input logic [result_w-1:0] expected,
		input logic [result_w-1:0] actual
	);
		if (expected !== actual) begin
			fail_cnt++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end else begin
			pass_cnt++;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && result_valid) begin
			if (exp_q.size() == 0) begin
				fail_cnt++;
				$display("A result came out at cycle %0d with no operation waiting for it", cyc);
			end else begin
				check(name_q[0], exp_q[0], result);
				check({name_q[0], " latency"}, due_q[0], cyc);
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
				void'(name_q.pop_front());
			end
		end
	end

	task automatic drive_op(
		input string             name,
		input op_t               op,
		input logic [data_w-1:0] x,
		input logic [data_w-1:0] y,
		input logic              flag
	);
		logic [result_w-1:0] exp;
		@(posedge clk);
		#2;
		op_valid = 1'b1;
		opcode = op;
		a = x;
		b = y;
		branch_flag = flag;
		if (op != op_nop && op != op_halt) begin
			exp = expected_result(op, x, y, flag, hi_m, lo_m);
			exp_q.push_back(exp);
			name_q.push_back(name);
			if (op == op_mul || op == op_div) begin
				due_q.push_back(cyc + muldiv_cycles + 2);
				hi_m = exp[result_w-1:data_w];
				lo_m = exp[data_w-1:0];
			end else begin
				due_q.push_back(cyc + 2);
			end
		end
	endtask

	// Strobe only in cycles where the DUT must be busy, so nothing is accepted
	task automatic drive_ignored(input logic exp_busy);
		@(posedge clk);
		#2;
		check("busy during multiply", exp_busy, busy);
		op_valid = exp_busy;
		opcode = op_t'($urandom);
		a = $urandom;
		b = $urandom;
		branch_flag = $urandom % 2;
	endtask

	task automatic wait_idle();
		@(posedge clk);
		#2;
		op_valid = 1'b0;
		while (exp_q.size() != 0 || busy) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic md_single(
		input string             name,
		input op_t               op,
		input logic [data_w-1:0] x,
		input logic [data_w-1:0] y
	);
		drive_op(name, op, x, y, 1'b0);
		wait_idle();
	endtask

	task automatic end_test(input string name);
		if (fail_cnt == test_base) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, fail_cnt - test_base);
		end
		test_base = fail_cnt;
	endtask

	initial begin
		int                amounts[4];
		op_t               shift_ops[4];
		logic [data_w-1:0] y;
		op_valid = 1'b0;
		opcode = op_nop;
		a = '0;
		b = '0;
		branch_flag = 1'b0;
		rst_n = 1'b0;
		pass_cnt = 0;
		fail_cnt = 0;
		test_base = 0;
		hi_m = '0;
		lo_m = '0;
		amounts = '{0, 31, 32, 63};
		shift_ops = '{op_shr, op_shl, op_ror, op_rol};
		void'($urandom(32'h1589));
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		check("reset result_valid", 0, result_valid);
		check("reset busy", 0, busy);
		drive_op("mfhi after reset", op_mfhi, $urandom, $urandom, 1'b0);
		drive_op("mflo after reset", op_mflo, $urandom, $urandom, 1'b0);
		wait_idle();
		end_test("reset");

		for (int i = 0; i < n_simple_ops; i++) begin
			for (int k = 0; k < n_reps; k++) begin
				drive_op($sformatf("random op %02h", simple_op(i)), simple_op(i),
					$urandom, $urandom, $urandom % 2);
			end
		end
		wait_idle();
		end_test("single-cycle random");

		for (int i = 0; i < 4; i++) begin
			for (int k = 0; k < 4; k++) begin
				drive_op($sformatf("op %02h by %0d", shift_ops[i], amounts[k]), shift_ops[i],
					$urandom, amounts[k], 1'b0);
			end
		end
		drive_op("branch taken", op_branch, 32'h0000_1000, 32'hffff_fff0, 1'b1);
		drive_op("branch not taken", op_branch, 32'h0000_1000, 32'hffff_fff0, 1'b0);
		drive_op("branch taken random", op_branch, $urandom, $urandom, 1'b1);
		drive_op("branch not taken random", op_branch, $urandom, $urandom, 1'b0);
		wait_idle();
		end_test("shift edges and branch");

		for (int k = 0; k < n_md_rand; k++) begin
			md_single("random mul", op_mul, $urandom, $urandom);
			y = $urandom;
			// Every other divisor is small so quotients are not all zero
			if (k % 2 == 1) begin
				y = {{20{y[31]}}, y[11:0]};
			end
			md_single("random div", op_div, $urandom, y);
		end
		md_single("mul -1 by -1", op_mul, -32'sd1, -32'sd1);
		md_single("mul min by -1", op_mul, 32'h8000_0000, -32'sd1);
		md_single("mul -7 by 3", op_mul, -32'sd7, 32'sd3);
		md_single("div -7 by 2", op_div, -32'sd7, 32'sd2);
		md_single("div 7 by -2", op_div, 32'sd7, -32'sd2);
		md_single("div -7 by -2", op_div, -32'sd7, -32'sd2);
		md_single("div 123 by 0", op_div, 32'sd123, 32'd0);
		md_single("div -123 by 0", op_div, -32'sd123, 32'd0);
		md_single("div min by -1", op_div, 32'h8000_0000, -32'sd1);
		end_test("multiply and divide");

		md_single("mul for readback", op_mul, -32'sd12345, 32'sd6789);
		drive_op("mfhi after mul", op_mfhi, $urandom, $urandom, 1'b0);
		drive_op("mflo after mul", op_mflo, $urandom, $urandom, 1'b0);
		wait_idle();
		md_single("div for readback", op_div, -32'sd1000, 32'sd7);
		drive_op("mfhi after div", op_mfhi, $urandom, $urandom, 1'b0);
		drive_op("mflo after div", op_mflo, $urandom, $urandom, 1'b0);
		wait_idle();
		end_test("hi lo readback");

		drive_op("mul under strobes", op_mul, $urandom, $urandom, 1'b0);
		// Busy covers the cycles up to and including the result strobe
		for (int i = 1; i <= 40; i++) begin
			drive_ignored(i <= muldiv_cycles + 2);
		end
		wait_idle();
		drive_op("halt", op_halt, $urandom, $urandom, 1'b0);
		drive_op("nop", op_nop, $urandom, $urandom, 1'b0);
		for (int u = 5'h13; u <= 5'h16; u++) begin
			drive_op($sformatf("unknown op %02h", u), op_t'(u), $urandom, $urandom, 1'b1);
		end
		for (int u = 5'h1b; u <= 5'h1f; u++) begin
			drive_op($sformatf("unknown op %02h", u), op_t'(u), $urandom, $urandom, 1'b1);
		end
		@(posedge clk);
		#2;
		op_valid = 1'b0;
		// Every remaining result is due two cycles after its strobe
		repeat (5) @(posedge clk);
		check("expected queue empty", 0, exp_q.size());
		end_test("ignored strobes and no-result ops");

		$display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		repeat (n_ops * 40 + 2000) @(posedge clk);
		$display("The run timed out at cycle %0d with %0d results still expected",
			cyc, exp_q.size());
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* compile.f */
alu_pkg.sv
alu_simple_unit.sv
alu_muldiv_unit.sv
alu_result_merge.sv
alu_core.sv
tb_alu_core.sv

/* Bender.yml */
package:
  name: alu_core

sources:
  - alu_pkg.sv
  - alu_simple_unit.sv
  - alu_muldiv_unit.sv
  - alu_result_merge.sv
  - alu_core.sv
  - target: simulation
    files:
      - tb_alu_core.sv
